//--- dv/mmio_golden.txt
// columns: opcode address store_data expected, all in hex
// opcodes 0 lb 1 lbu 2 lh 3 lhu 4 lw 5 sb 6 sh 7 sw 8 fetch 9 led A switches B uart F end
7 00000000 11223344 00000000
4 00000000 00000000 11223344
7 00000004 8899AABB 00000000
4 00000004 00000000 8899AABB
7 00002400 CAFEF00D 00000000
4 00002400 00000000 CAFEF00D
5 00000010 000000A1 00000000
5 00000011 FFFFFFB2 00000000
5 00000012 1234567C 00000000
5 00000013 0000008D 00000000
4 00000010 00000000 8D7CB2A1
0 00000010 00000000 FFFFFFA1
1 00000011 00000000 000000B2
0 00000012 00000000 0000007C
0 00000013 00000000 FFFFFF8D
1 00000013 00000000 0000008D
7 00000020 55555555 00000000
6 00000022 ABCD8001 00000000
4 00000020 00000000 80015555
2 00000022 00000000 FFFF8001
3 00000022 00000000 00008001
6 00000020 00007FFE 00000000
2 00000020 00000000 00007FFE
5 00000021 000000C3 00000000
4 00000020 00000000 8001C3FE
8 00000000 00000000 11223344
8 00000010 00000000 8D7CB2A1
8 00002400 00000000 CAFEF00D
7 00002404 FFFFFFFF 00000000
4 00002404 00000000 00000000
7 00010000 12345678 00000000
4 00000000 00000000 11223344
0 00031FFC 00000000 00000000
9 00032000 0000000A 0000000A
9 00032000 FFFFFFF5 00000005
4 00032000 00000000 00000005
A 00032004 00000000 00000000
B 00032008 0000005A 0000005A
B 00032008 000000C3 000000C3
F 00000000 00000000 00000000

//--- dv/mmio_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mmio_defines.svh"

module mmio_tb;

    localparam int MAX_LINES = 64;
    localparam int BIT_CYCLES = `MMIO_UART_CLKS_PER_BIT;
    localparam logic [31:0] STATUS_ADDR = `MMIO_GPIO_BASE + `MMIO_REG_STATUS;
    localparam logic [31:0] TXDATA_ADDR = `MMIO_GPIO_BASE + `MMIO_REG_TXDATA;
    localparam logic [31:0] SW_ADDR = `MMIO_GPIO_BASE + `MMIO_REG_SW;

    logic clk;
    logic rst_n;
    logic [31:0] pc;
    logic [31:0] address;
    logic [31:0] data_in;
    logic load_enable;
    logic store_enable;
    // one-hot opcode, bit n is golden opcode n
    logic [7:0] op;
    logic [3:0] sw;
    logic [31:0] data_out;
    logic [31:0] instr_out;
    logic [3:0] led;
    wire serial_loop;

    logic [31:0] golden [0:4*MAX_LINES-1];
    logic [15:0] lfsr;
    int check_errors;
    int timeout_errors;
    int other_errors;

    mmio dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .pc(pc),
        .address(address),
        .data_in(data_in),
        .load_enable(load_enable),
        .store_enable(store_enable),
        .is_lb(op[0]),
        .is_lbu(op[1]),
        .is_lh(op[2]),
        .is_lhu(op[3]),
        .is_lw(op[4]),
        .is_sb(op[5]),
        .is_sh(op[6]),
        .is_sw(op[7]),
        .uart_txd_in(serial_loop),
        .sw(sw),
        .data_out(data_out),
        .instr_out(instr_out),
        .led(led),
        .uart_rxd_out(serial_loop)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            value = {value[6:0], lfsr[0]};
        end
    endtask

    task automatic check_word(input string name, input mmio_pkg::mem_word_u expected,
                              input mmio_pkg::mem_word_u actual);
        if (actual !== expected) begin
            check_errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_led(input logic [3:0] expected, input logic [3:0] actual);
        if (actual !== expected) begin
            check_errors++;
            $display("CHECK FAILED at %0t ns: led expected %h got %h", $time, expected, actual);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            check_errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h got %h",
                     $time, name, expected, actual);
        end
    endtask

    // one data access, the answer is sampled half a clock after the read edge
    task automatic access(input logic [3:0] code, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic le,
                          output logic [31:0] rdata);
        @(posedge clk);
        address <= addr;
        data_in <= wdata;
        op <= 8'b1 << code;
        store_enable <= (code >= 4'd5);
        load_enable <= le;
        @(posedge clk);
        op <= '0;
        store_enable <= 1'b0;
        load_enable <= 1'b0;
        @(negedge clk);
        rdata = data_out;
    endtask

    task automatic fetch(input logic [31:0] addr, input logic [31:0] expected);
        @(posedge clk);
        pc <= addr;
        @(posedge clk);
        @(negedge clk);
        check_word("instr_out", expected, instr_out);
    endtask

    // each poll is one status load of two cycles
    task automatic wait_status(input int bit_index, input logic level, input string what,
                               output logic [31:0] status);
        int cycles;
        cycles = 0;
        access(4'd4, STATUS_ADDR, 32'h0, 1'b0, status);
        while (status[bit_index] !== level && cycles < 40 * BIT_CYCLES) begin
            access(4'd4, STATUS_ADDR, 32'h0, 1'b0, status);
            cycles += 2;
        end
        if (status[bit_index] !== level) begin
            timeout_errors++;
            $display("timeout at %0t ns: %s did not happen within %0d cycles",
                     $time, what, cycles);
        end
    endtask

    task automatic switch_read();
        logic [7:0] value;
        logic [31:0] word;
        random_bits(4, value);
        @(posedge clk);
        sw <= value[3:0];
        // two synchronizer stages before the register sees it
        repeat (3) @(posedge clk);
        access(4'd4, SW_ADDR, 32'h0, 1'b0, word);
        check_word("data_out (switches)", {28'h0, value[3:0]}, word);
    endtask

    task automatic uart_loopback(input logic [7:0] value, input logic [7:0] expected);
        logic [31:0] status;
        access(4'd7, TXDATA_ADDR, {24'h0, value}, 1'b0, status);
        // the transmitter is busy by now, so this byte has to vanish
        access(4'd7, TXDATA_ADDR, {24'h0, ~value}, 1'b0, status);
        wait_status(1, 1'b1, "receive flag rising", status);
        check_byte("status rx byte", expected, status[15:8]);
        access(4'd4, STATUS_ADDR, 32'h0, 1'b1, status);
        wait_status(0, 1'b0, "transmitter busy falling", status);
        // a second frame would have landed well inside this window
        repeat (12 * BIT_CYCLES) @(posedge clk);
        access(4'd4, STATUS_ADDR, 32'h0, 1'b0, status);
        check_word("status after frame", {16'h0, expected, 8'h00}, status);
    endtask

    initial begin
        logic [3:0] code;
        logic [31:0] word;
        logic [7:0] gap;
        int line;
        rst_n = 1'b0;
        pc = '0;
        address = '0;
        data_in = '0;
        load_enable = 1'b0;
        store_enable = 1'b0;
        op = '0;
        sw = '0;
        lfsr = 16'd69;
        check_errors = 0;
        timeout_errors = 0;
        other_errors = 0;
        $readmemh("dv/mmio_golden.txt", golden);
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        line = 0;
        while (line < MAX_LINES && golden[4*line] !== 32'hF && !$isunknown(golden[4*line])) begin
            code = golden[4*line][3:0];
            case (code)
                4'h8: fetch(golden[4*line+1], golden[4*line+3]);
                4'h9: begin
                    access(4'd7, golden[4*line+1], golden[4*line+2], 1'b0, word);
                    check_led(golden[4*line+3][3:0], led);
                end
                4'hA: switch_read();
                4'hB: uart_loopback(golden[4*line+2][7:0], golden[4*line+3][7:0]);
                default: begin
                    access(code, golden[4*line+1], golden[4*line+2], 1'b0, word);
                    if (code < 4'd5) begin
                        check_word("data_out", golden[4*line+3], word);
                    end
                end
            endcase
            random_bits(2, gap);
            repeat (gap) @(posedge clk);
            line++;
        end
        if (line == MAX_LINES || golden[4*line] !== 32'hF) begin
            other_errors++;
            $display("the golden file is missing, unreadable or has no end marker");
        end
        $display("errors: %0d check, %0d timeout, %0d other over %0d accesses",
                 check_errors, timeout_errors, other_errors, line);
        if (check_errors == 0 && timeout_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+logic
logic/mmio_pkg.sv
logic/dp_bram.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/gpio.sv
logic/mmio.sv
dv/mmio_tb.sv

//--- logic/dp_bram.sv
`timescale 1ns/1ns
`default_nettype none

`include "mmio_defines.svh"

module dp_bram (
    input wire clk,
    input wire [`MMIO_BRAM_AW-1:0] addr_a,
    input wire en_b,
    input wire [3:0] we_b,
    input wire [`MMIO_BRAM_AW-1:0] addr_b,
    input mmio_pkg::mem_word_u din_b,
    output logic [31:0] dout_a,
    output mmio_pkg::mem_word_u dout_b
);

    logic [3:0][7:0] mem [0:`MMIO_BRAM_WORDS-1];

    initial begin
        for (int i = 0; i < `MMIO_BRAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // instruction port, fetches past the end of RAM read as zero
    always_ff @(posedge clk) begin
        if (addr_a < `MMIO_BRAM_WORDS) begin
            dout_a <= mem[addr_a];
        end else begin
            dout_a <= '0;
        end
    end

    // data port is read-first, so a store returns the old word
    always_ff @(posedge clk) begin
        if (en_b) begin
            dout_b <= mem[addr_b];
            for (int i = 0; i < 4; i++) begin
                if (we_b[i]) begin
                    mem[addr_b][i] <= din_b.bytes[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/gpio.sv
`timescale 1ns/1ns
`default_nettype none

`include "mmio_defines.svh"

module gpio (
    input wire clk,
    input wire rst_n,
    input wire sel,
    input wire wr,
    input wire rd,
    input wire [3:0] offset,
    input wire [31:0] wdata,
    input wire uart_txd_in,
    input wire [3:0] sw,
    output mmio_pkg::mem_word_u rdata,
    output logic [3:0] led,
    output logic uart_rxd_out
);

    logic [3:0] sw_meta;
    logic [3:0] sw_sync;
    logic tx_start;
    logic [7:0] tx_byte;
    logic tx_busy;
    logic rx_done;
    logic [7:0] rx_byte;
    logic [7:0] rx_data;
    logic rx_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led <= 4'h0;
            sw_meta <= 4'h0;
            sw_sync <= 4'h0;
        end else begin
            sw_meta <= sw;
            sw_sync <= sw_meta;
            if (sel && wr && offset == `MMIO_REG_LED) begin
                led <= wdata[3:0];
            end
        end
    end

    // a byte written while a frame is pending or running is dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_start <= 1'b0;
        end else begin
            tx_start <= sel && wr && offset == `MMIO_REG_TXDATA && !tx_busy && !tx_start;
        end
    end

    always_ff @(posedge clk) begin
        if (sel && wr && offset == `MMIO_REG_TXDATA && !tx_busy && !tx_start) begin
            tx_byte <= wdata[7:0];
        end
    end

    // a new byte wins over a status read in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
        end else if (rx_done) begin
            rx_valid <= 1'b1;
        end else if (sel && rd && offset == `MMIO_REG_STATUS) begin
            rx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done) begin
            rx_data <= rx_byte;
        end
    end

    always_ff @(posedge clk) begin
        case (offset)
            `MMIO_REG_LED: rdata <= {28'h0, led};
            `MMIO_REG_SW: rdata <= {28'h0, sw_sync};
            `MMIO_REG_TXDATA: rdata <= {24'h0, tx_byte};
            `MMIO_REG_STATUS: rdata <= {16'h0, rx_data, 6'h0, rx_valid, tx_busy};
            default: rdata <= '0;
        endcase
    end

    uart_tx tx0 (
        .clk(clk),
        .rst_n(rst_n),
        .start(tx_start),
        .data(tx_byte),
        .txd(uart_rxd_out),
        .busy(tx_busy)
    );

    uart_rx rx0 (
        .clk(clk),
        .rst_n(rst_n),
        .rxd(uart_txd_in),
        .done(rx_done),
        .data(rx_byte)
    );

endmodule

`default_nettype wire

//--- logic/mmio.sv
`timescale 1ns/1ns
`default_nettype none

`include "mmio_defines.svh"

module mmio (
    input wire clk,
    input wire rst_n,
    input wire [31:0] pc,
    input wire [31:0] address,
    input wire [31:0] data_in,
    input wire load_enable,
    input wire store_enable,
    input wire is_lb,
    input wire is_lbu,
    input wire is_lh,
    input wire is_lhu,
    input wire is_lw,
    input wire is_sb,
    input wire is_sh,
    input wire is_sw,
    input wire uart_txd_in,
    input wire [3:0] sw,
    output logic [31:0] data_out,
    output logic [31:0] instr_out,
    output logic [3:0] led,
    output logic uart_rxd_out
);

    logic ram_sel;
    logic gpio_sel;
    logic store_any;
    logic [3:0] we_mask;
    mmio_pkg::mem_word_u store_word;
    mmio_pkg::mem_word_u ram_word;
    mmio_pkg::mem_word_u io_word;
    mmio_pkg::mem_word_u src_word;
    logic [7:0] sel_byte;
    logic [15:0] sel_half;

    // region and load opcode captured with the read request
    logic ram_q;
    logic gpio_q;
    logic [1:0] lane_q;
    logic lb_q;
    logic lbu_q;
    logic lh_q;
    logic lhu_q;
    logic lw_q;

    // anything between the top of RAM and the GPIO base is the gap
    assign ram_sel = address < `MMIO_BRAM_LIMIT;
    assign gpio_sel = address >= `MMIO_GPIO_BASE;
    assign store_any = is_sb | is_sh | is_sw;

    always_comb begin
        we_mask = 4'b0000;
        if (store_enable) begin
            if (is_sb) begin
                we_mask = 4'b0001 << address[1:0];
            end else if (is_sh) begin
                we_mask = address[1] ? 4'b1100 : 4'b0011;
            end else if (is_sw) begin
                we_mask = 4'b1111;
            end
        end
    end

    // the narrow value goes on every lane, the mask picks the one that lands
    always_comb begin
        if (is_sb) begin
            store_word.bytes = {4{data_in[7:0]}};
        end else if (is_sh) begin
            store_word.halves = {2{data_in[15:0]}};
        end else begin
            store_word = data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ram_q <= 1'b0;
            gpio_q <= 1'b0;
            lane_q <= 2'b00;
            {lb_q, lbu_q, lh_q, lhu_q, lw_q} <= 5'b00000;
        end else begin
            ram_q <= ram_sel;
            gpio_q <= gpio_sel;
            lane_q <= address[1:0];
            {lb_q, lbu_q, lh_q, lhu_q, lw_q} <= {is_lb, is_lbu, is_lh, is_lhu, is_lw};
        end
    end

    always_comb begin
        src_word = ram_q ? ram_word : (gpio_q ? io_word : '0);
        sel_byte = src_word.bytes[lane_q];
        sel_half = src_word.halves[lane_q[1]];
        if (lb_q) begin
            data_out = {{24{sel_byte[7]}}, sel_byte};
        end else if (lbu_q) begin
            data_out = {24'h0, sel_byte};
        end else if (lh_q) begin
            data_out = {{16{sel_half[15]}}, sel_half};
        end else if (lhu_q) begin
            data_out = {16'h0, sel_half};
        end else if (lw_q) begin
            data_out = src_word;
        end else begin
            data_out = '0;
        end
    end

    dp_bram bram (
        .clk(clk),
        .addr_a(pc[`MMIO_BRAM_AW+1:2]),
        .en_b(ram_sel),
        .we_b(we_mask),
        .addr_b(address[`MMIO_BRAM_AW+1:2]),
        .din_b(store_word),
        .dout_a(instr_out),
        .dout_b(ram_word)
    );

    gpio io (
        .clk(clk),
        .rst_n(rst_n),
        .sel(gpio_sel),
        .wr(store_enable & store_any),
        .rd(load_enable),
        .offset(address[3:0]),
        .wdata(data_in),
        .uart_txd_in(uart_txd_in),
        .sw(sw),
        .rdata(io_word),
        .led(led),
        .uart_rxd_out(uart_rxd_out)
    );

endmodule

`default_nettype wire

//--- logic/mmio_defines.svh
`ifndef MMIO_DEFINES_SVH
`define MMIO_DEFINES_SVH

// address map of the data port
`define MMIO_BRAM_LIMIT 32'h0000_2404
`define MMIO_GPIO_BASE 32'h0003_2000

// RAM geometry, the word index comes from address bits 13 to 2
`define MMIO_BRAM_WORDS 2305
`define MMIO_BRAM_AW 12

// GPIO register offsets, decoded from address bits 3 to 0
`define MMIO_REG_LED 4'h0
`define MMIO_REG_SW 4'h4
`define MMIO_REG_TXDATA 4'h8
`define MMIO_REG_STATUS 4'hC

// serial bit period in clock cycles
`define MMIO_UART_CLKS_PER_BIT 16

`endif

//--- logic/mmio_pkg.sv
`default_nettype none

package mmio_pkg;

    // one memory word, seen either as byte lanes or as half-word lanes
    typedef union packed {
        logic [3:0][7:0] bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

endpackage

`default_nettype wire

//--- logic/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

`include "mmio_defines.svh"

module uart_rx (
    input wire clk,
    input wire rst_n,
    input wire rxd,
    output logic done,
    output logic [7:0] data
);

    localparam int CLKS = `MMIO_UART_CLKS_PER_BIT;
    localparam int CW = $clog2(CLKS);
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;
    localparam logic [1:0] ST_STOP = 2'd3;

    logic rxd_meta;
    logic rxd_s;
    logic rxd_q;
    logic [1:0] state;
    logic [CW-1:0] baud_cnt;
    logic [2:0] bit_cnt;

    // the line idles high, so the synchronizer resets to one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {rxd_meta, rxd_s, rxd_q} <= 3'b111;
        end else begin
            {rxd_meta, rxd_s, rxd_q} <= {rxd, rxd_meta, rxd_s};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            baud_cnt <= '0;
            bit_cnt <= 3'd0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                ST_IDLE: begin
                    baud_cnt <= '0;
                    if (rxd_q && !rxd_s) state <= ST_START;
                end
                // a glitch shorter than half a bit is not a start bit
                ST_START: begin
                    if (baud_cnt == CW'(CLKS / 2 - 1)) begin
                        baud_cnt <= '0;
                        bit_cnt <= 3'd0;
                        state <= rxd_s ? ST_IDLE : ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (baud_cnt == CW'(CLKS - 1)) begin
                        baud_cnt <= '0;
                        data <= {rxd_s, data[7:1]};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) state <= ST_STOP;
                    end
                end
                default: begin
                    if (baud_cnt == CW'(CLKS - 1)) begin
                        done <= rxd_s;
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

`include "mmio_defines.svh"

module uart_tx (
    input wire clk,
    input wire rst_n,
    input wire start,
    input wire [7:0] data,
    output logic txd,
    output logic busy
);

    localparam int CLKS = `MMIO_UART_CLKS_PER_BIT;
    localparam int CW = $clog2(CLKS);

    logic [CW-1:0] baud_cnt;
    logic [3:0] bit_cnt;
    // data bits with the stop bit behind them
    logic [8:0] shreg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            txd <= 1'b1;
            busy <= 1'b0;
            baud_cnt <= '0;
            bit_cnt <= 4'd0;
            shreg <= '1;
        end else if (!busy) begin
            if (start) begin
                txd <= 1'b0;
                busy <= 1'b1;
                baud_cnt <= '0;
                bit_cnt <= 4'd0;
                shreg <= {1'b1, data};
            end
        end else if (baud_cnt == CW'(CLKS - 1)) begin
            baud_cnt <= '0;
            // bit 9 is the stop bit, the frame ends when it has run out
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                txd <= shreg[0];
                shreg <= {1'b1, shreg[8:1]};
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# builds the mmio testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f flist.f --top-module mmio_tb -o mmio_sim
./obj_dir/mmio_sim > sim.log 2>&1
cat sim.log
if grep -qx "TEST PASSED" sim.log; then
    exit 0
else
    exit 1
fi
